// File: hdl/tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// number of TLB entries and the width of an entry index
`define TLB_NUM     16
`define TLB_IDX_WD  4

// virtual page pair number, va[31:13]
`define VPN2_WD     19

// physical frame number, pa[31:12]
`define PFN_WD      20

// address space id
`define ASID_WD     8

`endif

// File: hdl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } acc_op_e;

    // priority order with the earliest check first
    typedef enum logic [2:0] {
        exc_none        = 3'd0,
        exc_adel        = 3'd1,
        exc_ades        = 3'd2,
        exc_tlbl_refill = 3'd3,
        exc_tlbs_refill = 3'd4,
        exc_tlbl_inval  = 3'd5,
        exc_tlbs_inval  = 3'd6,
        exc_mod         = 3'd7
    } exc_code_e;

    typedef enum logic [1:0] {
        bs_idle = 2'd0,
        bs_req  = 2'd1,
        bs_wait = 2'd2
    } bus_state_e;

endpackage

`default_nettype wire

// File: hdl/tlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb #(
    parameter int entry_num = `TLB_NUM,
    parameter int idx_wd    = `TLB_IDX_WD
) (
    input  logic                clk,
    input  logic                reset,
    // search port
    input  logic [`VPN2_WD-1:0] s_vpn2,
    input  logic                s_odd_page,
    input  logic [`ASID_WD-1:0] s_asid,
    output logic                s_found,
    output logic [`PFN_WD-1:0]  s_pfn,
    output logic                s_d,
    output logic                s_v,
    // write port
    input  logic                we,
    input  logic [idx_wd-1:0]   w_index,
    input  logic [`VPN2_WD-1:0] w_vpn2,
    input  logic [`ASID_WD-1:0] w_asid,
    input  logic                w_g,
    input  logic [`PFN_WD-1:0]  w_pfn0,
    input  logic                w_d0,
    input  logic                w_v0,
    input  logic [`PFN_WD-1:0]  w_pfn1,
    input  logic                w_d1,
    input  logic                w_v1
);

    // entry written since reset
    logic                tlb_e    [entry_num];
    logic                tlb_g    [entry_num];
    logic                tlb_v0   [entry_num];
    logic                tlb_v1   [entry_num];
    logic [`VPN2_WD-1:0] tlb_vpn2 [entry_num];
    logic [`ASID_WD-1:0] tlb_asid [entry_num];
    logic [`PFN_WD-1:0]  tlb_pfn0 [entry_num];
    logic                tlb_d0   [entry_num];
    logic [`PFN_WD-1:0]  tlb_pfn1 [entry_num];
    logic                tlb_d1   [entry_num];

    logic [entry_num-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entry_num; i++) begin
                tlb_e[i]  <= 1'b0;
                tlb_g[i]  <= 1'b0;
                tlb_v0[i] <= 1'b0;
                tlb_v1[i] <= 1'b0;
            end
        end else if (we) begin
            tlb_e[w_index]  <= 1'b1;
            tlb_g[w_index]  <= w_g;
            tlb_v0[w_index] <= w_v0;
            tlb_v1[w_index] <= w_v1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tlb_vpn2[w_index] <= w_vpn2;
            tlb_asid[w_index] <= w_asid;
            tlb_pfn0[w_index] <= w_pfn0;
            tlb_d0[w_index]   <= w_d0;
            tlb_pfn1[w_index] <= w_pfn1;
            tlb_d1[w_index]   <= w_d1;
        end
    end

    always_comb begin
        for (int i = 0; i < entry_num; i++) begin
            match[i] = tlb_e[i] && (tlb_vpn2[i] == s_vpn2)
                       && (tlb_g[i] || (tlb_asid[i] == s_asid));
        end
    end

    // odd page bit picks the half of the pair
    always_comb begin
        s_pfn = '0;
        s_d   = 1'b0;
        s_v   = 1'b0;
        for (int i = 0; i < entry_num; i++) begin
            if (match[i]) begin
                s_pfn = s_odd_page ? tlb_pfn1[i] : tlb_pfn0[i];
                s_d   = s_odd_page ? tlb_d1[i]   : tlb_d0[i];
                s_v   = s_odd_page ? tlb_v1[i]   : tlb_v0[i];
            end
        end
    end

    assign s_found = |match;

    // software must never load overlapping entries
    assert property (@(posedge clk) disable iff (reset) $onehot0(match))
        else $error("tlb: more than one entry matches vpn2 %h", s_vpn2);

endmodule

`default_nettype wire

// File: hdl/addr_check_stage.sv
`timescale 1ns/1ps
`default_nettype none

module addr_check_stage
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  acc_op_e     req_op,
    input  logic [31:0] req_vaddr,
    input  logic [31:0] req_wdata,
    input  logic [3:0]  req_wstrb,
    input  logic        tx_allowin,
    output logic        req_allowin,
    output logic        ac_to_tx_valid,
    output acc_op_e     ac_op,
    output logic [31:0] ac_vaddr,
    output logic [31:0] ac_wdata,
    output logic [3:0]  ac_wstrb,
    output exc_code_e   ac_exc
);

    exc_code_e align_exc;

    // word accesses only
    always_comb begin
        if (req_vaddr[1:0] != 2'b00) begin
            align_exc = (req_op == op_store) ? exc_ades : exc_adel;
        end else begin
            align_exc = exc_none;
        end
    end

    // the item leaves once downstream takes it
    assign req_allowin = !ac_to_tx_valid || tx_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ac_to_tx_valid <= 1'b0;
        end else if (req_allowin) begin
            ac_to_tx_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_allowin) begin
            ac_op    <= req_op;
            ac_vaddr <= req_vaddr;
            ac_wdata <= req_wdata;
            ac_wstrb <= req_wstrb;
            ac_exc   <= align_exc;
        end
    end

    assert property (@(posedge clk) reset |=> !ac_to_tx_valid)
        else $error("addr_check_stage: valid set right after reset");

endmodule

`default_nettype wire

// File: hdl/tlb_xlat_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_xlat_stage
    import mmu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ac_to_tx_valid,
    input  acc_op_e             ac_op,
    input  logic [31:0]         ac_vaddr,
    input  logic [31:0]         ac_wdata,
    input  logic [3:0]          ac_wstrb,
    input  exc_code_e           ac_exc,
    input  logic [`ASID_WD-1:0] asid,
    input  logic                s_found,
    input  logic [`PFN_WD-1:0]  s_pfn,
    input  logic                s_d,
    input  logic                s_v,
    input  logic                ba_allowin,
    output logic                tx_allowin,
    output logic [`VPN2_WD-1:0] s_vpn2,
    output logic                s_odd_page,
    output logic [`ASID_WD-1:0] s_asid,
    output logic                tx_to_ba_valid,
    output acc_op_e             ba_op,
    output logic [31:0]         ba_paddr,
    output logic [31:0]         ba_wdata,
    output logic [3:0]          ba_wstrb,
    output exc_code_e           ba_exc
);

    acc_op_e     tx_op;
    logic [31:0] tx_vaddr;
    logic [31:0] tx_wdata;
    logic [3:0]  tx_wstrb;
    exc_code_e   tx_exc;

    assign tx_allowin = !tx_to_ba_valid || ba_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_to_ba_valid <= 1'b0;
        end else if (tx_allowin) begin
            tx_to_ba_valid <= ac_to_tx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ac_to_tx_valid && tx_allowin) begin
            tx_op    <= ac_op;
            tx_vaddr <= ac_vaddr;
            tx_wdata <= ac_wdata;
            tx_wstrb <= ac_wstrb;
            tx_exc   <= ac_exc;
        end
    end

    // same-cycle search on the held item
    assign s_vpn2     = tx_vaddr[31:13];
    assign s_odd_page = tx_vaddr[12];
    assign s_asid     = asid;

    // address error from the first stage outranks every tlb fault
    always_comb begin
        if (tx_exc != exc_none) begin
            ba_exc = tx_exc;
        end else if (!s_found) begin
            ba_exc = (tx_op == op_store) ? exc_tlbs_refill : exc_tlbl_refill;
        end else if (!s_v) begin
            ba_exc = (tx_op == op_store) ? exc_tlbs_inval : exc_tlbl_inval;
        end else if (tx_op == op_store && !s_d) begin
            ba_exc = exc_mod;
        end else begin
            ba_exc = exc_none;
        end
    end

    assign ba_paddr = {s_pfn, tx_vaddr[11:0]};
    assign ba_op    = tx_op;
    assign ba_wdata = tx_wdata;
    assign ba_wstrb = tx_wstrb;

endmodule

`default_nettype wire

// File: hdl/bus_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module bus_access_stage
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_to_ba_valid,
    input  acc_op_e     ba_op,
    input  logic [31:0] ba_paddr,
    input  logic [31:0] ba_wdata,
    input  logic [3:0]  ba_wstrb,
    input  exc_code_e   ba_exc,
    input  logic        data_sram_addr_ok,
    input  logic        data_sram_data_ok,
    input  logic [31:0] data_sram_rdata,
    output logic        ba_allowin,
    output logic        data_sram_req,
    output logic        data_sram_wr,
    output logic [3:0]  data_sram_wstrb,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic        resp_valid,
    output exc_code_e   resp_exc,
    output logic [31:0] resp_rdata
);

    bus_state_e  state;
    logic        item_valid;
    acc_op_e     item_op;
    logic [31:0] item_paddr;
    logic [31:0] item_wdata;
    logic [3:0]  item_wstrb;
    exc_code_e   item_exc;
    logic        item_done;
    logic        take_new;

    // faults skip the bus and finish right away
    assign item_done = item_valid
                       && ((item_exc != exc_none) || (state == bs_wait && data_sram_data_ok));
    assign ba_allowin = !item_valid || item_done;
    assign take_new   = tx_to_ba_valid && ba_allowin && (ba_exc == exc_none);

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
        end else if (ba_allowin) begin
            item_valid <= tx_to_ba_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_to_ba_valid && ba_allowin) begin
            item_op    <= ba_op;
            item_paddr <= ba_paddr;
            item_wdata <= ba_wdata;
            item_wstrb <= ba_wstrb;
            item_exc   <= ba_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bs_idle;
        end else begin
            case (state)
                bs_idle: if (take_new) state <= bs_req;
                bs_req:  if (data_sram_addr_ok) state <= bs_wait;
                bs_wait: if (data_sram_data_ok) state <= take_new ? bs_req : bs_idle;
                default: state <= bs_idle;
            endcase
        end
    end

    assign data_sram_req   = (state == bs_req);
    assign data_sram_wr    = (item_op == op_store);
    assign data_sram_wstrb = item_wstrb;
    assign data_sram_addr  = item_paddr;
    assign data_sram_wdata = item_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= item_done;
        end
    end

    // only a clean load returns data
    always_ff @(posedge clk) begin
        if (item_done) begin
            resp_exc   <= item_exc;
            resp_rdata <= (item_exc == exc_none && item_op == op_load) ? data_sram_rdata : '0;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        data_sram_req && !data_sram_addr_ok |=> data_sram_req && $stable(data_sram_addr))
        else $error("bus_access_stage: req dropped or addr changed before addr_ok");

    assert property (@(posedge clk) disable iff (reset) state == bs_idle |-> !data_sram_data_ok)
        else $error("bus_access_stage: data_ok with no transaction outstanding");

endmodule

`default_nettype wire

// File: hdl/mem_xlat_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module mem_xlat_top
    import mmu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // request side
    input  logic                  req_valid,
    input  acc_op_e               req_op,
    input  logic [31:0]           req_vaddr,
    input  logic [31:0]           req_wdata,
    input  logic [3:0]            req_wstrb,
    output logic                  req_allowin,
    input  logic [`ASID_WD-1:0]   asid,
    // tlb write port
    input  logic                  tlb_we,
    input  logic [`TLB_IDX_WD-1:0] tlb_w_index,
    input  logic [`VPN2_WD-1:0]   tlb_w_vpn2,
    input  logic [`ASID_WD-1:0]   tlb_w_asid,
    input  logic                  tlb_w_g,
    input  logic [`PFN_WD-1:0]    tlb_w_pfn0,
    input  logic                  tlb_w_d0,
    input  logic                  tlb_w_v0,
    input  logic [`PFN_WD-1:0]    tlb_w_pfn1,
    input  logic                  tlb_w_d1,
    input  logic                  tlb_w_v1,
    // sram-like data bus
    output logic                  data_sram_req,
    output logic                  data_sram_wr,
    output logic [3:0]            data_sram_wstrb,
    output logic [31:0]           data_sram_addr,
    output logic [31:0]           data_sram_wdata,
    input  logic                  data_sram_addr_ok,
    input  logic                  data_sram_data_ok,
    input  logic [31:0]           data_sram_rdata,
    // response strobe
    output logic                  resp_valid,
    output exc_code_e             resp_exc,
    output logic [31:0]           resp_rdata
);

    logic                tx_allowin;
    logic                ba_allowin;
    logic                ac_to_tx_valid;
    logic                tx_to_ba_valid;
    acc_op_e             ac_op;
    logic [31:0]         ac_vaddr;
    logic [31:0]         ac_wdata;
    logic [3:0]          ac_wstrb;
    exc_code_e           ac_exc;
    acc_op_e             ba_op;
    logic [31:0]         ba_paddr;
    logic [31:0]         ba_wdata;
    logic [3:0]          ba_wstrb;
    exc_code_e           ba_exc;

    // tlb search port
    logic [`VPN2_WD-1:0] s_vpn2;
    logic                s_odd_page;
    logic [`ASID_WD-1:0] s_asid;
    logic                s_found;
    logic [`PFN_WD-1:0]  s_pfn;
    logic                s_d;
    logic                s_v;

    addr_check_stage i_addr_check_stage (.*);

    tlb_xlat_stage i_tlb_xlat_stage (.*);

    bus_access_stage i_bus_access_stage (.*);

    tlb #(
        .entry_num (`TLB_NUM),
        .idx_wd    (`TLB_IDX_WD)
    ) i_tlb (
        .clk,
        .reset,
        .s_vpn2,
        .s_odd_page,
        .s_asid,
        .s_found,
        .s_pfn,
        .s_d,
        .s_v,
        .we        (tlb_we),
        .w_index   (tlb_w_index),
        .w_vpn2    (tlb_w_vpn2),
        .w_asid    (tlb_w_asid),
        .w_g       (tlb_w_g),
        .w_pfn0    (tlb_w_pfn0),
        .w_d0      (tlb_w_d0),
        .w_v0      (tlb_w_v0),
        .w_pfn1    (tlb_w_pfn1),
        .w_d1      (tlb_w_d1),
        .w_v1      (tlb_w_v1)
    );

endmodule

`default_nettype wire

// File: tb/tb_mem_xlat.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tb_mem_xlat
    import mmu_pkg::*;
();

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    acc_op_e                req_op;
    logic [31:0]            req_vaddr;
    logic [31:0]            req_wdata;
    logic [3:0]             req_wstrb;
    logic                   req_allowin;
    logic [`ASID_WD-1:0]    asid;
    logic                   tlb_we;
    logic [`TLB_IDX_WD-1:0] tlb_w_index;
    logic [`VPN2_WD-1:0]    tlb_w_vpn2;
    logic [`ASID_WD-1:0]    tlb_w_asid;
    logic                   tlb_w_g;
    logic [`PFN_WD-1:0]     tlb_w_pfn0;
    logic                   tlb_w_d0;
    logic                   tlb_w_v0;
    logic [`PFN_WD-1:0]     tlb_w_pfn1;
    logic                   tlb_w_d1;
    logic                   tlb_w_v1;
    logic                   data_sram_req;
    logic                   data_sram_wr;
    logic [3:0]             data_sram_wstrb;
    logic [31:0]            data_sram_addr;
    logic [31:0]            data_sram_wdata;
    logic                   data_sram_addr_ok;
    logic                   data_sram_data_ok;
    logic [31:0]            data_sram_rdata;
    logic                   resp_valid;
    exc_code_e              resp_exc;
    logic [31:0]            resp_rdata;

    // one expected response per request
    exc_code_e   exp_exc_q[$];
    logic [31:0] exp_rdata_q[$];
    // expected bus transfers of fault-free requests
    logic [31:0] exp_paddr_q[$];
    acc_op_e     exp_op_q[$];
    logic [31:0] exp_wdata_q[$];
    logic [3:0]  exp_wstrb_q[$];

    logic [31:0] sram_mem[logic [31:0]];
    logic [31:0] lfsr_state;
    int          line_total = 0;

    mem_xlat_top i_mem_xlat_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_exc(input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: resp_exc is %s, expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_op(input acc_op_e got, input acc_op_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: bus op is %s, expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_wstrb(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: data_sram_wstrb is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: resp_rdata is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_wdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: data_sram_wdata is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_paddr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %0t: data_sram_addr is %h, expected %h", $time, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int cycles);
        cycles = 0;
        repeat (2) begin
            lfsr_state = lfsr_step(lfsr_state);
            cycles = (cycles << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic lookup_exc(input string name, output exc_code_e code);
        exc_code_e e;
        e = e.first();
        code = e;
        repeat (e.num()) begin
            if (e.name() == name) begin
                code = e;
                return;
            end
            e = e.next();
        end
        abort_run($sformatf("unknown exception name %s in the stimulus file", name));
    endtask

    // sram address phase checks the transfer and returns the load word
    task automatic accept_address(output logic [31:0] word);
        logic [31:0] key;
        logic [31:0] cur;
        acc_op_e     op;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        if (exp_paddr_q.size() == 0) begin
            abort_run("bus request seen although every outstanding request should fault");
        end
        check_paddr(data_sram_addr, exp_paddr_q.pop_front());
        op    = exp_op_q.pop_front();
        wdata = exp_wdata_q.pop_front();
        wstrb = exp_wstrb_q.pop_front();
        check_op(data_sram_wr ? op_store : op_load, op);
        key = {data_sram_addr[31:2], 2'b00};
        cur = sram_mem.exists(key) ? sram_mem[key] : (key ^ 32'h5a5a_a5a5);
        word = cur;
        if (op == op_store) begin
            check_wstrb(data_sram_wstrb, wstrb);
            check_wdata(data_sram_wdata, wdata);
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wstrb[b]) begin
                    cur[8*b +: 8] = data_sram_wdata[8*b +: 8];
                end
            end
            sram_mem[key] = cur;
            word = '0;
        end
    endtask

    // sram-like slave with 0 to 3 cycles of delay per phase
    initial begin
        int          wait_cnt;
        logic        data_pending;
        logic [31:0] load_word;
        data_sram_addr_ok = 1'b0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        data_pending      = 1'b0;
        load_word         = '0;
        lfsr_state        = 32'hb31c_b72b;
        draw_delay(wait_cnt);
        forever begin
            @(posedge clk);
            #1;
            data_sram_addr_ok = 1'b0;
            data_sram_data_ok = 1'b0;
            data_sram_rdata   = '0;
            if (reset) begin
                data_pending = 1'b0;
            end else if (data_pending) begin
                if (wait_cnt == 0) begin
                    data_sram_data_ok = 1'b1;
                    data_sram_rdata   = load_word;
                    data_pending      = 1'b0;
                    draw_delay(wait_cnt);
                end else begin
                    wait_cnt--;
                end
            end else if (data_sram_req) begin
                if (wait_cnt == 0) begin
                    data_sram_addr_ok = 1'b1;
                    accept_address(load_word);
                    data_pending = 1'b1;
                    draw_delay(wait_cnt);
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // response monitor
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && resp_valid) begin
                if (exp_exc_q.size() == 0) begin
                    abort_run("response strobe seen with no request outstanding");
                end
                check_exc(resp_exc, exp_exc_q.pop_front());
                check_rdata(resp_rdata, exp_rdata_q.pop_front());
            end
        end
    end

    initial begin
        wait (line_total != 0);
        repeat (line_total * 200) @(posedge clk);
        abort_run($sformatf("watchdog: run did not finish within %0d cycles", line_total * 200));
    end

    task automatic wait_idle();
        while (exp_exc_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_request(input acc_op_e op, input logic [31:0] vaddr,
                                input logic [31:0] wdata, input logic [3:0] wstrb,
                                input exc_code_e exc, input logic [31:0] rdata,
                                input logic [31:0] paddr);
        logic taken;
        exp_exc_q.push_back(exc);
        exp_rdata_q.push_back(rdata);
        if (exc == exc_none) begin
            exp_paddr_q.push_back(paddr);
            exp_op_q.push_back(op);
            exp_wdata_q.push_back(wdata);
            exp_wstrb_q.push_back(wstrb);
        end
        req_valid = 1'b1;
        req_op    = op;
        req_vaddr = vaddr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_allowin;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       lines[$];
        string       op_s;
        string       exc_s;
        acc_op_e     op;
        exc_code_e   exc;
        logic [31:0] vaddr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] paddr;
        logic [3:0]  wstrb;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_op      = op_load;
        req_vaddr   = '0;
        req_wdata   = '0;
        req_wstrb   = '0;
        asid        = '0;
        tlb_we      = 1'b0;
        tlb_w_index = '0;
        tlb_w_vpn2  = '0;
        tlb_w_asid  = '0;
        tlb_w_g     = 1'b0;
        tlb_w_pfn0  = '0;
        tlb_w_d0    = 1'b0;
        tlb_w_v0    = 1'b0;
        tlb_w_pfn1  = '0;
        tlb_w_d1    = 1'b0;
        tlb_w_v1    = 1'b0;

        fd = $fopen("tb/xlat_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tb/xlat_input.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        line_total = lines.size();

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (lines[i]) begin
            if (lines[i].substr(0, 0) == "w") begin
                // tlb writes only with the pipeline empty
                wait_idle();
                n = $sscanf(lines[i], "w %h %h %h %h %h %h %h %h %h %h", tlb_w_index,
                            tlb_w_vpn2, tlb_w_asid, tlb_w_g, tlb_w_pfn0, tlb_w_d0,
                            tlb_w_v0, tlb_w_pfn1, tlb_w_d1, tlb_w_v1);
                if (n != 10) begin
                    abort_run($sformatf("bad tlb write line: %s", lines[i]));
                end
                tlb_we = 1'b1;
                @(posedge clk);
                #1;
                tlb_we = 1'b0;
            end else if (lines[i].substr(0, 0) == "a") begin
                wait_idle();
                n = $sscanf(lines[i], "a %h", asid);
                if (n != 1) begin
                    abort_run($sformatf("bad asid line: %s", lines[i]));
                end
            end else begin
                n = $sscanf(lines[i], "r %s %h %h %h %s %h %h", op_s, vaddr, wdata, wstrb,
                            exc_s, rdata, paddr);
                if (n != 7 || (op_s != "ld" && op_s != "st")) begin
                    abort_run($sformatf("bad request line: %s", lines[i]));
                end
                op = (op_s == "st") ? op_store : op_load;
                lookup_exc(exc_s, exc);
                send_request(op, vaddr, wdata, wstrb, exc, rdata, paddr);
            end
        end

        wait_idle();
        // a few idle cycles to catch stray strobes
        repeat (10) @(posedge clk);
        if (exp_paddr_q.size() != 0) begin
            $display("%0d expected bus transfers never happened", exp_paddr_q.size());
            $display("=== FAIL ===");
            $fatal(1, "missing bus transfers");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/xlat_input.txt
# w: index vpn2 asid g pfn0 d0 v0 pfn1 d1 v1 (tlb write) | a: asid
# r: op vaddr wdata wstrb exc rdata paddr (paddr is 0 where the request faults)
a 01
w 0 00200 01 0 01000 1 1 01001 0 1
w 1 00201 01 0 02000 1 0 02001 1 1
w 2 40000 07 1 00030 1 1 00031 1 1
r ld 00400010 00000000 f exc_none 5b5aa5b5 01000010
r ld 00401ffc 00000000 f exc_none 5b5aba59 01001ffc
r st 00400020 12345678 f exc_none 00000000 01000020
r ld 00400020 00000000 f exc_none 12345678 01000020
r st 00401000 11111111 f exc_mod 00000000 00000000
r ld 00402004 00000000 f exc_tlbl_inval 00000000 00000000
r st 00402008 22222222 f exc_tlbs_inval 00000000 00000000
r ld 00403008 00000000 f exc_none 585ab5ad 02001008
r ld 10000000 00000000 f exc_tlbl_refill 00000000 00000000
r st 10000004 33333333 f exc_tlbs_refill 00000000 00000000
r ld 10000002 00000000 f exc_adel 00000000 00000000
r st 00400001 44444444 f exc_ades 00000000 00000000
r ld 80000100 00000000 f exc_none 5a59a4a5 00030100
a 02
r ld 00400010 00000000 f exc_tlbl_refill 00000000 00000000
r ld 80001ff0 00000000 f exc_none 5a59ba55 00031ff0
a 01
r st 00400024 cafef00d f exc_none 00000000 01000024
r ld 00400024 00000000 f exc_none cafef00d 01000024
r st 00400028 aabbccdd 3 exc_none 00000000 01000028
r ld 00400028 00000000 f exc_none 5b5accdd 01000028
r ld 00401004 00000000 f exc_none 5b5ab5a1 01001004
r st 00401008 55555555 f exc_mod 00000000 00000000
r ld 00400011 00000000 f exc_adel 00000000 00000000
r ld 00400010 00000000 f exc_none 5b5aa5b5 01000010
r ld 80000004 00000000 f exc_none 5a59a5a1 00030004

// File: src.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/tlb.sv
hdl/addr_check_stage.sv
hdl/tlb_xlat_stage.sv
hdl/bus_access_stage.sv
hdl/mem_xlat_top.sv
tb/tb_mem_xlat.sv

// File: Bender.yml
package:
  name: mem_xlat

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mmu_pkg.sv
      - hdl/tlb.sv
      - hdl/addr_check_stage.sv
      - hdl/tlb_xlat_stage.sv
      - hdl/bus_access_stage.sv
      - hdl/mem_xlat_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_mem_xlat.sv
